// File: all.f
+incdir+rtl
rtl/daq_pkg.sv
rtl/adc_frame_if.sv
rtl/adc_capture.sv
rtl/phase_meter.sv
rtl/host_regs.sv
rtl/daq_top.sv
bench/daq_checker.sv
bench/daq_tb.sv

// File: bench/daq_checker.sv
`timescale 1ns/1ps
`default_nettype none

module daq_checker (
	input  wire                       AD_CLK_40M,
	input  wire                       rst_i,
	input  wire                       adc_convst_n_i,
	input  wire                       adc_rd_n_i,
	input  wire                       adc_cs_n_i,
	input  wire                       frame_done_i
);

	a_convst_rd_apart: assert property (@(posedge AD_CLK_40M) disable iff (rst_i)
		!(!adc_convst_n_i && !adc_rd_n_i))
		else $error("convst_n and rd_n low in the same cycle");

	a_rd_inside_cs: assert property (@(posedge AD_CLK_40M) disable iff (rst_i)
		!adc_rd_n_i |-> !adc_cs_n_i)
		else $error("rd_n low while cs_n is high");

	a_done_pulse: assert property (@(posedge AD_CLK_40M) disable iff (rst_i)
		frame_done_i |=> !frame_done_i)
		else $error("frame_done held for more than one cycle");

endmodule

bind adc_capture daq_checker u_checker (
	.AD_CLK_40M     (AD_CLK_40M),
	.rst_i          (rst_i),
	.adc_convst_n_i (adc_convst_n_o),
	.adc_rd_n_i     (adc_rd_n_o),
	.adc_cs_n_i     (adc_cs_n_o),
	.frame_done_i   (frm.frame_done)
);

`default_nettype wire

// File: bench/daq_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "daq_defs.svh"

module daq_tb;

	// reset, registers, acquisition and disable, then three phase periods and the loss wait
	localparam int LEN_FIXED   = 40 + 80 + 700 + 1200;
	localparam int LEN_PHASE   = 3 * 2000 + 40 + `DAQ_PHASE_TIMEOUT + 60;
	localparam int CYCLE_LIMIT = LEN_FIXED + LEN_PHASE + 1000;

	logic                    AD_CLK_40M = 1'b0;
	logic                    rst_i = 1'b1;
	logic                    bus_cs_n = 1'b1;
	logic                    bus_we_n = 1'b1;
	logic                    bus_rd_n = 1'b1;
	logic [`DAQ_ADDR_W-1:0]  bus_addr = '0;
	logic [`DAQ_DATA_W-1:0]  bus_wdata = '0;
	logic [`DAQ_DATA_W-1:0]  bus_rdata;
	logic [`DAQ_DATA_W-1:0]  adc_db = '0;
	logic                    adc_busy = 1'b0;
	logic                    adc_convst_n;
	logic                    adc_rd_n;
	logic                    adc_cs_n;
	logic                    adc_reset;
	logic                    phase = 1'b0;
	logic [15:0]             lfsr_q = 16'd60523;
	int                      cycle_cnt = 0;
	logic [`DAQ_DATA_W-1:0]  model_words [`DAQ_N_CH];     // words of the current conversion
	int                      busy_timer = 0;
	int                      rd_idx = 0;
	logic                    frame_open = 1'b0;           // convst seen, words still to come
	logic                    conv_last = 1'b1;
	logic                    rd_last = 1'b1;
	logic                    conv_fell = 1'b0;
	logic                    rd_fell = 1'b0;

	daq_top dut0 (
		.AD_CLK_40M(AD_CLK_40M), .rst_i(rst_i),
		.bus_cs_n_i(bus_cs_n), .bus_we_n_i(bus_we_n), .bus_rd_n_i(bus_rd_n),
		.bus_addr_i(bus_addr), .bus_data_i(bus_wdata), .bus_data_o(bus_rdata),
		.adc_db_i(adc_db), .adc_busy_i(adc_busy), .adc_convst_n_o(adc_convst_n),
		.adc_rd_n_o(adc_rd_n), .adc_cs_n_o(adc_cs_n), .adc_reset_o(adc_reset),
		.phase_i(phase)
	);

	always #5 AD_CLK_40M = ~AD_CLK_40M;

	// galois lfsr, one step per bit
	function automatic logic [15:0] lfsr_take(input int nbits);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			v      = {v[14:0], lfsr_q[0]};
			lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
		end
		return v;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("Fail %s: read 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	always @(posedge AD_CLK_40M) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT)
			stop_run("timeout, the tests did not finish within the cycle limit");
	end

	////////////////////////////////////////////////////////////
	// adc model
	////////////////////////////////////////////////////////////

	always @(negedge AD_CLK_40M) begin
		conv_fell = conv_last && !adc_convst_n;              // strobes sampled mid-cycle
		rd_fell   = rd_last && !adc_rd_n;
		conv_last = adc_convst_n;
		rd_last   = adc_rd_n;
		if (rd_fell && adc_cs_n)
			stop_run("rd_n fell while cs_n was high, the adc was not selected");
	end

	always @(posedge AD_CLK_40M) begin
		if (rst_i) begin
			busy_timer <= 0;
			adc_busy   <= 1'b0;
			frame_open <= 1'b0;
		end else begin
			if (conv_fell) begin
				for (int c = 0; c < `DAQ_N_CH; c++)
					model_words[c] = lfsr_take(`DAQ_DATA_W);
				rd_idx     <= 0;
				busy_timer <= 1;
				frame_open <= 1'b1;
			end else if (busy_timer != 0) begin
				adc_busy   <= (busy_timer >= 2 && busy_timer < 22);   // 20 cycles high
				busy_timer <= (busy_timer == 22) ? 0 : busy_timer + 1;
			end
			if (rd_fell) begin
				adc_db <= model_words[rd_idx];                   // next channel on each rd fall
				rd_idx <= rd_idx + 1;
				if (rd_idx == `DAQ_N_CH - 1)
					frame_open <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// host bus
	////////////////////////////////////////////////////////////

	task automatic bus_write(input logic [`DAQ_ADDR_W-1:0] addr, input logic [15:0] data);
		@(posedge AD_CLK_40M);
		bus_cs_n  <= 1'b0;
		bus_we_n  <= 1'b0;
		bus_addr  <= addr;
		bus_wdata <= data;
		@(posedge AD_CLK_40M);                               // write lands on this edge
		bus_cs_n  <= 1'b1;
		bus_we_n  <= 1'b1;
	endtask

	task automatic bus_read(input logic [`DAQ_ADDR_W-1:0] addr, output logic [15:0] data);
		@(posedge AD_CLK_40M);
		bus_cs_n <= 1'b0;
		bus_rd_n <= 1'b0;
		bus_addr <= addr;
		@(negedge AD_CLK_40M);
		data = bus_rdata;                                    // read path is combinational
		@(posedge AD_CLK_40M);
		bus_cs_n <= 1'b1;
		bus_rd_n <= 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		logic [15:0] d;
		bus_read(daq_pkg::VERSION, d);
		check("version", d, `DAQ_VERSION);
		bus_read(daq_pkg::STATUS, d);
		check("status", d, 16'h0002);
		@(negedge AD_CLK_40M);
		check("adc_convst_n_o", adc_convst_n, 1'b1);
		check("adc_rd_n_o", adc_rd_n, 1'b1);
		check("adc_cs_n_o", adc_cs_n, 1'b1);
		check("adc_reset_o", adc_reset, 1'b0);
	endtask

	task automatic test_registers();
		logic [15:0] d;
		bus_write(daq_pkg::SAMPLE_DIV, 16'hA5C3);
		bus_read(daq_pkg::SAMPLE_DIV, d);
		check("sample_div", d, 16'hA5C3);
		bus_write(daq_pkg::SAMPLE_DIV, 16'h0000);           // pacer stays stopped
		bus_write(daq_pkg::AD_ENABLE, 16'h0001);
		bus_read(daq_pkg::AD_ENABLE, d);
		check("ad_enable", d, 16'h0001);
		bus_write(daq_pkg::AD_ENABLE, 16'h0000);
		bus_write(daq_pkg::AD_RESET, 16'h0001);
		@(negedge AD_CLK_40M);
		check("adc_reset_o", adc_reset, 1'b1);
		bus_read(daq_pkg::AD_RESET, d);
		check("ad_reset", d, 16'h0001);
		bus_write(daq_pkg::AD_RESET, 16'h0000);
		@(negedge AD_CLK_40M);
		check("adc_reset_o", adc_reset, 1'b0);
		bus_read(9'h004, d);
		check("unmapped 0x004", d, 16'h0000);
		bus_read(9'h1FE, d);
		check("unmapped 0x1fe", d, 16'h0000);
	endtask

	task automatic test_acquisition();
		logic [15:0] d;
		int          polls;
		bus_write(daq_pkg::SAMPLE_DIV, 16'd200);
		bus_write(daq_pkg::AD_ENABLE, 16'h0001);
		polls = 0;
		d     = '0;
		while (!d[0]) begin
			if (polls == 400)
				stop_run("frame_ready was never set after acquisition was enabled");
			bus_read(daq_pkg::STATUS, d);
			polls++;
		end
		bus_read(daq_pkg::STATUS, d);
		check("status.frame_ready", d[0], 1'b0);           // cleared by the poll read
		for (int c = 0; c < `DAQ_N_CH; c++) begin
			bus_read(9'(daq_pkg::CH0_DATA + 2 * c), d);
			check($sformatf("ch%0d_data", c), d, model_words[c]);
		end
	endtask

	task automatic test_disable();
		bus_write(daq_pkg::AD_ENABLE, 16'h0000);
		repeat (3) @(negedge AD_CLK_40M);                    // a start already issued may still come
		while (frame_open)
			@(negedge AD_CLK_40M);
		repeat (1000) begin
			@(negedge AD_CLK_40M);
			if (!adc_convst_n)
				stop_run("convst_n went low after acquisition was disabled");
		end
	endtask

	task automatic test_phase();
		logic [15:0] lo;
		logic [15:0] hi;
		int          spacing;
		@(posedge AD_CLK_40M);
		spacing = 100 + int'(lfsr_take(11) % 1901);
		for (int e = 0; e < 3; e++) begin
			phase <= 1'b1;
			repeat (10) @(posedge AD_CLK_40M);
			phase <= 1'b0;
			repeat (spacing - 10) @(posedge AD_CLK_40M);
		end
		bus_read(daq_pkg::PHASE_L, lo);
		bus_read(daq_pkg::PHASE_H, hi);
		check("period", {hi, lo}, spacing);
		bus_read(daq_pkg::STATUS, lo);
		check("status.phase_error", lo[1], 1'b0);
	endtask

	task automatic test_phase_loss();
		logic [15:0] d;
		repeat (`DAQ_PHASE_TIMEOUT + 10) @(posedge AD_CLK_40M);
		bus_read(daq_pkg::PHASE_L, d);
		check("phase_l", d, 16'h0000);
		bus_read(daq_pkg::PHASE_H, d);
		check("phase_h", d, 16'h0000);
		bus_read(daq_pkg::STATUS, d);
		check("status.phase_error", d[1], 1'b1);
	endtask

	initial begin
		repeat (2) @(posedge AD_CLK_40M);
		rst_i <= 1'b0;
		test_reset_state();
		test_registers();
		test_acquisition();
		test_disable();
		test_phase();
		test_phase_loss();
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/adc_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "daq_defs.svh"

module adc_capture (
	input  wire                AD_CLK_40M,
	input  wire                rst_i,
	adc_frame_if.engine        frm,
	input  wire daq_pkg::sample_t adc_db_i,
	input  wire                adc_busy_i,
	output logic               adc_convst_n_o,
	output logic               adc_rd_n_o,
	output logic               adc_cs_n_o
);

	logic [`DAQ_DATA_W-1:0]            div_cnt;      // pacing counter
	logic                              tick;         // start request
	daq_pkg::adc_state_e               state;
	logic [3:0]                        step_cnt;     // cycles inside convst or one read
	logic [$clog2(`DAQ_N_CH)-1:0]      ch_idx;       // channel being read
	daq_pkg::sample_frame_t            frame_q;

	////////////////////////////////////////////////////////////
	// sample pacing
	////////////////////////////////////////////////////////////

	always_ff @(posedge AD_CLK_40M) begin
		if (rst_i) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else if (frm.enable && (frm.sample_div != '0)) begin
			if (div_cnt >= frm.sample_div - 1'b1) begin
				div_cnt <= '0;
				tick    <= 1'b1;                         // one start per sample_div cycles
			end else begin
				div_cnt <= div_cnt + 1'b1;
				tick    <= 1'b0;
			end
		end else begin
			div_cnt <= '0;                               // stopped, restart from zero
			tick    <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// convert / busy / read sequence
	////////////////////////////////////////////////////////////

	always_ff @(posedge AD_CLK_40M) begin
		if (rst_i) begin
			state    <= daq_pkg::IDLE;
			step_cnt <= '0;
			ch_idx   <= '0;
		end else begin
			case (state)
				daq_pkg::IDLE: begin
					step_cnt <= '0;
					ch_idx   <= '0;
					if (tick)                            // ticks elsewhere are dropped
						state <= daq_pkg::CONVST;
				end
				daq_pkg::CONVST: begin
					if (step_cnt == 4'(`DAQ_CONVST_CYCLES - 1)) begin
						step_cnt <= '0;
						state    <= daq_pkg::WAIT_BUSY_HI;
					end else begin
						step_cnt <= step_cnt + 1'b1;
					end
				end
				daq_pkg::WAIT_BUSY_HI: begin
					if (adc_busy_i)
						state <= daq_pkg::WAIT_BUSY_LO;
				end
				daq_pkg::WAIT_BUSY_LO: begin
					if (!adc_busy_i)                     // conversion finished
						state <= daq_pkg::READ;
				end
				daq_pkg::READ: begin
					if (step_cnt == 4'(`DAQ_RD_CYCLES - 1) &&
						ch_idx == ($clog2(`DAQ_N_CH))'(`DAQ_N_CH - 1)) begin
						state <= daq_pkg::DONE;          // no gap after the last word
					end else if (step_cnt == 4'(`DAQ_RD_CYCLES)) begin
						step_cnt <= '0;                  // rd_n high cycle over
						ch_idx   <= ch_idx + 1'b1;
					end else begin
						step_cnt <= step_cnt + 1'b1;
					end
				end
				daq_pkg::DONE: begin
					state <= daq_pkg::IDLE;
				end
				default: begin
					state <= daq_pkg::IDLE;
				end
			endcase
		end
	end

	// word is taken on the last low cycle of rd_n
	always_ff @(posedge AD_CLK_40M) begin
		if (state == daq_pkg::READ && step_cnt == 4'(`DAQ_RD_CYCLES - 1))
			frame_q[ch_idx] <= adc_db_i;
	end

	////////////////////////////////////////////////////////////
	// adc strobes and frame output
	////////////////////////////////////////////////////////////

	assign adc_convst_n_o = (state != daq_pkg::CONVST);
	assign adc_cs_n_o     = (state != daq_pkg::READ);
	assign adc_rd_n_o     = !(state == daq_pkg::READ && step_cnt < 4'(`DAQ_RD_CYCLES));

	assign frm.frame      = frame_q;
	assign frm.frame_done = (state == daq_pkg::DONE);   // all channels stored here

endmodule

`default_nettype wire

// File: rtl/adc_frame_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "daq_defs.svh"

interface adc_frame_if;

	logic                     enable;         // acquisition on
	logic [`DAQ_DATA_W-1:0]   sample_div;     // cycles between starts, 0 = stopped
	daq_pkg::sample_frame_t   frame;          // valid while frame_done is high
	logic                     frame_done;     // one cycle per conversion

	// host register side
	modport ctrl (
		output enable,
		output sample_div,
		input  frame,
		input  frame_done
	);

	// capture engine side
	modport engine (
		input  enable,
		input  sample_div,
		output frame,
		output frame_done
	);

endinterface

`default_nettype wire

// File: rtl/daq_defs.svh
`ifndef DAQ_DEFS_SVH
`define DAQ_DEFS_SVH

////////////////////////////////////////////////////////////
// bus and sample sizes
////////////////////////////////////////////////////////////

`define DAQ_DATA_W          16          // host bus and adc word
`define DAQ_ADDR_W          9           // host bus address
`define DAQ_N_CH            8           // channels per conversion
`define DAQ_PERIOD_W        32          // key-phase period count

`define DAQ_VERSION         16'h1000    // version register contents

////////////////////////////////////////////////////////////
// adc strobe timing, in AD_CLK_40M cycles
////////////////////////////////////////////////////////////

`define DAQ_CONVST_CYCLES   2           // convst low time
`define DAQ_RD_CYCLES       2           // rd low time per channel

////////////////////////////////////////////////////////////
// key-phase meter
////////////////////////////////////////////////////////////

// no edge for this many cycles means the sensor is lost
`define DAQ_PHASE_TIMEOUT   4096

`endif

// File: rtl/daq_pkg.sv
`default_nettype none

`include "daq_defs.svh"

package daq_pkg;

	typedef logic [`DAQ_DATA_W-1:0] sample_t;                 // one adc word
	typedef sample_t [`DAQ_N_CH-1:0] sample_frame_t;           // index = channel

	// capture engine states
	typedef enum logic [2:0] {
		IDLE,
		CONVST,                                                // convst_n low
		WAIT_BUSY_HI,
		WAIT_BUSY_LO,
		READ,                                                  // rd_n strobes, cs_n low
		DONE                                                   // frame_done cycle
	} adc_state_e;

	// host register map, word addresses in steps of 2
	typedef enum logic [`DAQ_ADDR_W-1:0] {
		VERSION    = 9'h000,
		SAMPLE_DIV = 9'h002,
		PHASE_L    = 9'h00A,
		PHASE_H    = 9'h00C,
		AD_ENABLE  = 9'h00E,
		AD_RESET   = 9'h010,
		STATUS     = 9'h014,
		CH0_DATA   = 9'h016,
		CH1_DATA   = 9'h018,
		CH2_DATA   = 9'h01A,
		CH3_DATA   = 9'h01C,
		CH4_DATA   = 9'h01E,
		CH5_DATA   = 9'h020,
		CH6_DATA   = 9'h022,
		CH7_DATA   = 9'h024
	} reg_addr_e;

endpackage

`default_nettype wire

// File: rtl/daq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "daq_defs.svh"

module daq_top (
	input  wire                      AD_CLK_40M,
	input  wire                      rst_i,
	// host bus
	input  wire                      bus_cs_n_i,
	input  wire                      bus_we_n_i,
	input  wire                      bus_rd_n_i,
	input  wire [`DAQ_ADDR_W-1:0]    bus_addr_i,
	input  wire [`DAQ_DATA_W-1:0]    bus_data_i,
	output logic [`DAQ_DATA_W-1:0]   bus_data_o,
	// adc
	input  wire [`DAQ_DATA_W-1:0]    adc_db_i,
	input  wire                      adc_busy_i,
	output logic                     adc_convst_n_o,
	output logic                     adc_rd_n_o,
	output logic                     adc_cs_n_o,
	output logic                     adc_reset_o,
	// key phase
	input  wire                      phase_i
);

	logic [`DAQ_PERIOD_W-1:0]   period;
	logic                       phase_error;

	adc_frame_if frm_if ();                              // host_regs <-> capture

	adc_capture u_adc_capture (
		.AD_CLK_40M     (AD_CLK_40M),
		.rst_i          (rst_i),
		.frm            (frm_if.engine),
		.adc_db_i       (adc_db_i),
		.adc_busy_i     (adc_busy_i),
		.adc_convst_n_o (adc_convst_n_o),
		.adc_rd_n_o     (adc_rd_n_o),
		.adc_cs_n_o     (adc_cs_n_o)
	);

	phase_meter u_phase_meter (
		.AD_CLK_40M     (AD_CLK_40M),
		.rst_i          (rst_i),
		.phase_i        (phase_i),
		.period_o       (period),
		.phase_error_o  (phase_error)
	);

	host_regs u_host_regs (
		.AD_CLK_40M     (AD_CLK_40M),
		.rst_i          (rst_i),
		.bus_cs_n_i     (bus_cs_n_i),
		.bus_we_n_i     (bus_we_n_i),
		.bus_rd_n_i     (bus_rd_n_i),
		.bus_addr_i     (bus_addr_i),
		.bus_data_i     (bus_data_i),
		.bus_data_o     (bus_data_o),
		.frm            (frm_if.ctrl),
		.period_i       (period),
		.phase_error_i  (phase_error),
		.adc_reset_o    (adc_reset_o)
	);

endmodule

`default_nettype wire

// File: rtl/host_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "daq_defs.svh"

module host_regs (
	input  wire                        AD_CLK_40M,
	input  wire                        rst_i,
	input  wire                        bus_cs_n_i,
	input  wire                        bus_we_n_i,
	input  wire                        bus_rd_n_i,
	input  wire [`DAQ_ADDR_W-1:0]      bus_addr_i,
	input  wire [`DAQ_DATA_W-1:0]      bus_data_i,
	output logic [`DAQ_DATA_W-1:0]     bus_data_o,
	adc_frame_if.ctrl                  frm,
	input  wire [`DAQ_PERIOD_W-1:0]    period_i,
	input  wire                        phase_error_i,
	output logic                       adc_reset_o
);

	daq_pkg::reg_addr_e          addr;
	logic                        wr_en;
	logic                        rd_en;
	logic [`DAQ_DATA_W-1:0]      sample_div_q;
	logic                        enable_q;
	logic                        ad_reset_q;
	logic                        frame_ready_q;
	daq_pkg::sample_frame_t      ch_q;           // latest sample per channel
	logic [`DAQ_DATA_W-1:0]      rdata;

	assign addr  = daq_pkg::reg_addr_e'(bus_addr_i);
	assign wr_en = !bus_cs_n_i && !bus_we_n_i;
	assign rd_en = !bus_cs_n_i && !bus_rd_n_i;

	////////////////////////////////////////////////////////////
	// control registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge AD_CLK_40M) begin
		if (rst_i) begin
			sample_div_q <= '0;
			enable_q     <= 1'b0;
			ad_reset_q   <= 1'b0;
		end else if (wr_en) begin
			case (addr)
				daq_pkg::SAMPLE_DIV: sample_div_q <= bus_data_i;
				daq_pkg::AD_ENABLE:  enable_q     <= bus_data_i[0];
				daq_pkg::AD_RESET:   ad_reset_q   <= bus_data_i[0];
				default: ;                           // read-only or unmapped
			endcase
		end
	end

	// new frame wins over a status read in the same cycle
	always_ff @(posedge AD_CLK_40M) begin
		if (rst_i)
			frame_ready_q <= 1'b0;
		else if (frm.frame_done)
			frame_ready_q <= 1'b1;
		else if (rd_en && addr == daq_pkg::STATUS)
			frame_ready_q <= 1'b0;                   // clear on read
	end

	always_ff @(posedge AD_CLK_40M) begin
		if (frm.frame_done)
			ch_q <= frm.frame;
	end

	////////////////////////////////////////////////////////////
	// read multiplexer
	////////////////////////////////////////////////////////////

	always_comb begin
		rdata = '0;
		if (rd_en) begin
			case (addr)
				daq_pkg::VERSION:    rdata = `DAQ_VERSION;
				daq_pkg::SAMPLE_DIV: rdata = sample_div_q;
				daq_pkg::PHASE_L:    rdata = period_i[`DAQ_DATA_W-1:0];
				daq_pkg::PHASE_H:    rdata = period_i[`DAQ_PERIOD_W-1:`DAQ_DATA_W];
				daq_pkg::AD_ENABLE:  rdata = {{(`DAQ_DATA_W-1){1'b0}}, enable_q};
				daq_pkg::AD_RESET:   rdata = {{(`DAQ_DATA_W-1){1'b0}}, ad_reset_q};
				daq_pkg::STATUS:     rdata = {{(`DAQ_DATA_W-2){1'b0}}, phase_error_i,
					frame_ready_q};
				daq_pkg::CH0_DATA:   rdata = ch_q[0];
				daq_pkg::CH1_DATA:   rdata = ch_q[1];
				daq_pkg::CH2_DATA:   rdata = ch_q[2];
				daq_pkg::CH3_DATA:   rdata = ch_q[3];
				daq_pkg::CH4_DATA:   rdata = ch_q[4];
				daq_pkg::CH5_DATA:   rdata = ch_q[5];
				daq_pkg::CH6_DATA:   rdata = ch_q[6];
				daq_pkg::CH7_DATA:   rdata = ch_q[7];
				default:             rdata = '0;     // unmapped
			endcase
		end
	end

	assign bus_data_o     = rdata;
	assign frm.enable     = enable_q;
	assign frm.sample_div = sample_div_q;
	assign adc_reset_o    = ad_reset_q;

endmodule

`default_nettype wire

// File: rtl/phase_meter.sv
`timescale 1ns/1ps
`default_nettype none

`include "daq_defs.svh"

module phase_meter (
	input  wire                       AD_CLK_40M,
	input  wire                       rst_i,
	input  wire                       phase_i,
	output logic [`DAQ_PERIOD_W-1:0]  period_o,
	output logic                      phase_error_o
);

	logic                       ph_meta;      // first sync stage
	logic                       ph_sync;      // second sync stage
	logic                       ph_prev;
	logic                       rise;
	logic                       seen;         // an edge has been seen since timeout
	logic [`DAQ_PERIOD_W-1:0]   cnt_q;        // cycles since the last edge
	logic [`DAQ_PERIOD_W-1:0]   period_q;

	always_ff @(posedge AD_CLK_40M) begin
		if (rst_i) begin
			ph_meta <= 1'b0;
			ph_sync <= 1'b0;
			ph_prev <= 1'b0;
		end else begin
			ph_meta <= phase_i;
			ph_sync <= ph_meta;
			ph_prev <= ph_sync;
		end
	end

	assign rise = ph_sync && !ph_prev;

	// cnt_q holds k at the k-th edge after a phase pulse
	always_ff @(posedge AD_CLK_40M) begin
		if (rst_i) begin
			seen     <= 1'b0;
			cnt_q    <= '0;
			period_q <= '0;
		end else if (rise) begin
			if (seen)
				period_q <= cnt_q;                     // first edge only arms the counter
			cnt_q <= `DAQ_PERIOD_W'(1);
			seen  <= 1'b1;
		end else if (seen) begin
			if (cnt_q == `DAQ_PERIOD_W'(`DAQ_PHASE_TIMEOUT)) begin
				period_q <= '0;                        // pulse lost
				seen     <= 1'b0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	assign period_o      = period_q;
	assign phase_error_o = (period_q == '0);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the daq testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module daq_tb -o daq_sim
./obj_dir/daq_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
exit 0
